//--- verilog/uart_cfg_pkg.sv
package uart_cfg_pkg;

    // one frame is start, DATA_BITS data bits LSB first, even parity and one stop bit
    localparam int DATA_BITS = 8;

    typedef logic [DATA_BITS-1:0] uart_byte_t;

    // position of a data bit within the byte
    typedef logic [2:0] bit_index_t;

    // clocks within one bit period, enough for clks_per_baud up to 2047
    typedef logic [10:0] baud_cnt_t;

endpackage

//--- verilog/uart_msg_pkg.sv
package uart_msg_pkg;
    import uart_cfg_pkg::*;

    // send is a one-cycle strobe and data is only looked at while it is high
    typedef struct packed {
        logic       send;
        uart_byte_t data;
    } tx_req_t;

    // received byte plus the checks made on its frame
    typedef struct packed {
        uart_byte_t data;
        logic       parity_err; // data bits plus parity bit held an odd number of ones
        logic       frame_err;  // stop bit was sampled low
    } rx_word_t;

endpackage

//--- verilog/uart_tx.sv
module uart_tx
    import uart_cfg_pkg::*;
    import uart_msg_pkg::*;
#(
    parameter int clks_per_baud = 1041
) (
    input  logic    clk,
    input  logic    nRst,
    input  tx_req_t tx_req,
    output logic    tx_serial,
    output logic    tx_busy
);

    typedef enum logic [2:0] {
        IDLE,
        START,
        DATA,
        PARITY,
        STOP
    } tx_state_t;

    localparam baud_cnt_t bit_last = baud_cnt_t'(clks_per_baud - 1);
    localparam bit_index_t idx_last = bit_index_t'(DATA_BITS - 1);

    tx_state_t  state, next_state;
    baud_cnt_t  baud_cnt, next_baud_cnt;
    bit_index_t bit_index, next_bit_index;
    uart_byte_t shift_reg, next_shift_reg;
    logic       par_bit, next_par_bit;
    logic       next_serial;
    logic       bit_done;

    assign bit_done = (baud_cnt == bit_last);

    always_comb begin
        next_state     = state;
        next_baud_cnt  = baud_cnt + 1'b1;
        next_bit_index = bit_index;
        next_shift_reg = shift_reg;
        next_par_bit   = par_bit;

        case (state)
            IDLE: begin
                next_baud_cnt = '0;
                if (tx_req.send) begin // a strobe while busy never reaches this branch
                    next_state     = START;
                    next_shift_reg = tx_req.data;
                    next_par_bit   = 1'b0;
                    next_bit_index = '0;
                end
            end
            START: begin
                if (bit_done) begin
                    next_state    = DATA;
                    next_baud_cnt = '0;
                end
            end
            DATA: begin
                if (bit_done) begin
                    next_baud_cnt = '0;
                    // fold the bit just sent into the parity before shifting it out
                    next_par_bit   = par_bit ^ shift_reg[0];
                    next_shift_reg = shift_reg >> 1;
                    next_bit_index = bit_index + 1'b1;
                    if (bit_index == idx_last)
                        next_state = PARITY;
                end
            end
            PARITY: begin
                if (bit_done) begin
                    next_state    = STOP;
                    next_baud_cnt = '0;
                end
            end
            STOP: begin
                if (bit_done) begin
                    next_state    = IDLE;
                    next_baud_cnt = '0;
                end
            end
            default: begin
                next_state    = IDLE;
                next_baud_cnt = '0;
            end
        endcase
    end

    // next_serial is the line level for the coming cycle and feeds the tx_serial flop
    always_comb begin
        case (next_state)
            START:   next_serial = 1'b0;
            DATA:    next_serial = next_shift_reg[0];
            PARITY:  next_serial = next_par_bit;
            default: next_serial = 1'b1; // idle and stop both hold the line high
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state     <= IDLE;
            baud_cnt  <= '0;
            bit_index <= '0;
            tx_serial <= 1'b1;
            tx_busy   <= 1'b0;
        end else begin
            state     <= next_state;
            baud_cnt  <= next_baud_cnt;
            bit_index <= next_bit_index;
            tx_serial <= next_serial;
            tx_busy   <= (next_state != IDLE);
        end
    end

    always_ff @(posedge clk) begin
        shift_reg <= next_shift_reg;
        par_bit   <= next_par_bit;
    end

endmodule

//--- verilog/uart_rx.sv
module uart_rx
    import uart_cfg_pkg::*;
    import uart_msg_pkg::*;
#(
    parameter int clks_per_baud = 1041
) (
    input  logic     clk,
    input  logic     nRst,
    input  logic     rx_serial,
    input  logic     rec_ready,
    output rx_word_t rx_word,
    output logic     rx_valid
);

    typedef enum logic [2:0] {
        IDLE,
        START,
        DATAIN,
        PARITY,
        STOP,
        CLEAN
    } rx_state_t;

    localparam baud_cnt_t bit_last = baud_cnt_t'(clks_per_baud - 1);
    localparam baud_cnt_t half_last = baud_cnt_t'((clks_per_baud - 1) / 2);
    localparam bit_index_t idx_last = bit_index_t'(DATA_BITS - 1);

    rx_state_t  state, next_state;
    baud_cnt_t  baud_cnt, next_baud_cnt;
    bit_index_t bit_index, next_bit_index;
    uart_byte_t byte_reg, next_byte_reg;
    logic       par_bit, next_par_bit;
    rx_word_t   next_word;
    logic       next_valid;
    logic       bit_done;

    // every sample after the start check lands a full bit period after the last one
    assign bit_done = (baud_cnt == bit_last);

    always_comb begin
        next_state     = state;
        next_baud_cnt  = baud_cnt + 1'b1;
        next_bit_index = bit_index;
        next_byte_reg  = byte_reg;
        next_par_bit   = par_bit;
        next_word      = rx_word;
        next_valid     = 1'b0;

        case (state)
            IDLE: begin
                next_baud_cnt = '0;
                if (!rx_serial && rec_ready)
                    next_state = START;
            end
            START: begin
                if (baud_cnt == half_last) begin
                    next_baud_cnt = '0;
                    // a low line at mid start bit is a real frame, anything else was a glitch
                    if (!rx_serial && rec_ready) begin
                        next_state     = DATAIN;
                        next_bit_index = '0;
                        next_par_bit   = 1'b0;
                    end else begin
                        next_state = IDLE;
                    end
                end
            end
            DATAIN: begin
                if (bit_done) begin
                    next_baud_cnt            = '0;
                    next_byte_reg[bit_index] = rx_serial;
                    next_par_bit             = par_bit ^ rx_serial;
                    next_bit_index           = bit_index + 1'b1;
                    if (bit_index == idx_last)
                        next_state = PARITY;
                end
            end
            PARITY: begin
                if (bit_done) begin
                    next_baud_cnt = '0;
                    next_par_bit  = par_bit ^ rx_serial; // ends up high on an odd count of ones
                    next_state    = STOP;
                end
            end
            STOP: begin
                if (bit_done) begin
                    next_baud_cnt        = '0;
                    next_valid           = 1'b1;
                    next_word.data       = byte_reg;
                    next_word.parity_err = par_bit;
                    next_word.frame_err  = ~rx_serial;
                    next_state           = CLEAN;
                end
            end
            CLEAN: begin
                next_baud_cnt = '0;
                next_state    = IDLE;
            end
            default: begin
                next_baud_cnt = '0;
                next_state    = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state     <= IDLE;
            baud_cnt  <= '0;
            bit_index <= '0;
            rx_word   <= '0;
            rx_valid  <= 1'b0;
        end else begin
            state     <= next_state;
            baud_cnt  <= next_baud_cnt;
            bit_index <= next_bit_index;
            rx_word   <= next_word;  // holds until the next stop sample
            rx_valid  <= next_valid; // high only on the cycle after the stop sample edge
        end
    end

    always_ff @(posedge clk) begin
        byte_reg <= next_byte_reg;
        par_bit  <= next_par_bit;
    end

endmodule

//--- verilog/uart_link_top.sv
module uart_link_top
    import uart_msg_pkg::*;
#(
    parameter int clks_per_baud = 1041
) (
    input  logic     clk,
    input  logic     nRst,

    input  tx_req_t  tx_req,
    output logic     tx_serial,
    output logic     tx_busy,

    input  logic     rx_serial,
    input  logic     rec_ready,
    output rx_word_t rx_word,
    output logic     rx_valid
);

    // the two directions share only the clock and reset
    // the serial loop between them is closed outside this block

    uart_tx #(
        .clks_per_baud(clks_per_baud)
    ) u_tx (
        .clk      (clk),
        .nRst     (nRst),
        .tx_req   (tx_req),
        .tx_serial(tx_serial),
        .tx_busy  (tx_busy)
    );

    uart_rx #(
        .clks_per_baud(clks_per_baud)
    ) u_rx (
        .clk      (clk),
        .nRst     (nRst),
        .rx_serial(rx_serial),
        .rec_ready(rec_ready), // frames are only picked up while the host can take them
        .rx_word  (rx_word),
        .rx_valid (rx_valid)
    );

endmodule

//--- dv/uart_link_tb.sv
module uart_link_tb
    import uart_cfg_pkg::*;
    import uart_msg_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N = 16; // clocks per bit in this bench

    logic     clk;
    logic     nRst;
    tx_req_t  tx_req;
    logic     tx_serial;
    logic     tx_busy;
    logic     rx_serial;
    logic     rec_ready;
    rx_word_t rx_word;
    logic     rx_valid;

    logic     loop_mode; // high routes tx_serial back into the receiver
    logic     bang_line;
    int       cycle_cnt;
    int       cycle_limit;
    int       case_cyc;
    int       pulses;
    rx_word_t got_word;
    logic [31:0] rng;
    string    cur_name;

    string      case_names[$];
    string      case_kinds[$];
    uart_byte_t case_bytes[$];
    int         case_reps[$];
    int         total_frames;

    uart_link_top #(
        .clks_per_baud(N)
    ) u_dut (
        .clk      (clk),
        .nRst     (nRst),
        .tx_req   (tx_req),
        .tx_serial(tx_serial),
        .tx_busy  (tx_busy),
        .rx_serial(rx_serial),
        .rec_ready(rec_ready),
        .rx_word  (rx_word),
        .rx_valid (rx_valid)
    );

    assign rx_serial = loop_mode ? tx_serial : bang_line;

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
            abort_run("timeout: the run went past its cycle limit");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_val(input string what, input int expected, input int actual);
        if (expected != actual)
            abort_run($sformatf("mismatch %s %s: expected 0x%0h actual 0x%0h",
                                cur_name, what, expected, actual));
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // a case kind needs this many slots of 13 bit periods and a silent wait takes one too
    function automatic int frame_weight(input string kind);
        if (kind == "notready")
            return 3;
        else if (kind == "busy")
            return 2;
        else if (kind == "loop" || kind == "badpar" || kind == "badstop" || kind == "rand")
            return 1;
        return 0;
    endfunction

    task automatic read_cases();
        int               fd;
        int               code;
        int               rep_v;
        logic [8*32-1:0]  name_v;
        logic [8*32-1:0]  kind_v;
        logic [8*256-1:0] line_v;
        uart_byte_t       byte_v;
        string            kind_s;
        fd = $fopen("dv/uart_cases.txt", "r");
        if (fd == 0)
            abort_run("could not open dv/uart_cases.txt");
        total_frames = 0;
        while (!$feof(fd)) begin
            name_v = '0;
            kind_v = '0;
            code = $fscanf(fd, "%s", name_v);
            if (code != 1)
                break;
            if (name_v == "#") begin
                code = $fgets(line_v, fd); // rest of a comment line
                continue;
            end
            code = $fscanf(fd, "%s %h %d", kind_v, byte_v, rep_v);
            if (code != 3)
                abort_run("a line of the case file could not be read");
            kind_s = string'(kind_v);
            if (frame_weight(kind_s) == 0)
                abort_run($sformatf("unknown case kind %s in the case file", kind_s));
            case_names.push_back(string'(name_v));
            case_kinds.push_back(kind_s);
            case_bytes.push_back(byte_v);
            case_reps.push_back(rep_v);
            total_frames += frame_weight(kind_s) * rep_v;
        end
        $fclose(fd);
    endtask

    // wait one clock and look at the outputs once they have settled
    task automatic tick();
        @(posedge clk);
        #1;
        case_cyc++;
        if (rx_valid) begin
            pulses++;
            got_word = rx_word;
        end
    endtask

    task automatic start_frame();
        case_cyc = 0;
        pulses   = 0;
    endtask

    task automatic wait_valid();
        while (pulses == 0 && case_cyc < 12 * N)
            tick();
        if (pulses == 0)
            abort_run($sformatf("no byte was received in case %s", cur_name));
    endtask

    task automatic check_word(input uart_byte_t data, input logic par_err, input logic frm_err);
        check_val("data", data, got_word.data);
        check_val("parity_err", par_err, got_word.parity_err);
        check_val("frame_err", frm_err, got_word.frame_err);
    endtask

    // start bit, data LSB first, even parity and stop bit are each held one bit period
    task automatic bang_frame(input uart_byte_t b, input logic flip_par, input logic low_stop);
        logic [10:0] frame;
        frame = {~low_stop, (^b) ^ flip_par, b, 1'b0};
        for (int i = 0; i < 11; i++) begin
            bang_line = frame[i];
            repeat (N) tick();
        end
        bang_line = 1'b1;
    endtask

    task automatic loop_byte(input uart_byte_t b);
        int rise_at;
        int fall_at;
        rise_at     = 0;
        fall_at     = 0;
        loop_mode   = 1'b1;
        start_frame();
        tx_req.data = b;
        tx_req.send = 1'b1;
        while ((fall_at == 0 || pulses == 0) && case_cyc < 12 * N) begin
            tick();
            if (case_cyc == 1)
                tx_req.send = 1'b0;
            if (tx_busy && rise_at == 0)
                rise_at = case_cyc;
            if (!tx_busy && rise_at != 0 && fall_at == 0)
                fall_at = case_cyc;
        end
        if (pulses == 0)
            abort_run($sformatf("no byte was received on the looped line in case %s", cur_name));
        if (fall_at == 0)
            abort_run($sformatf("the transmitter stayed busy too long in case %s", cur_name));
        check_val("tx_busy rise", 1, rise_at);
        check_val("tx_busy fall", 11 * N + 1, fall_at);
        check_val("rx_valid pulses", 1, pulses);
        check_word(b, 1'b0, 1'b0);
    endtask

    task automatic bang_checked(input uart_byte_t b, input logic flip_par, input logic low_stop);
        loop_mode = 1'b0;
        start_frame();
        bang_frame(b, flip_par, low_stop); // the report lands inside the stop bit
        wait_valid();
        check_val("rx_valid pulses", 1, pulses);
        check_word(b, flip_par, low_stop);
    endtask

    task automatic not_ready_case(input uart_byte_t b);
        rx_word_t saved;
        loop_mode = 1'b0;
        saved     = rx_word;
        rec_ready = 1'b0;
        start_frame();
        bang_frame(b, 1'b0, 1'b0);
        while (case_cyc < 12 * N)
            tick();
        check_val("pulses while not ready", 0, pulses);
        check_val("rx_word held", saved, rx_word);
        rec_ready = 1'b1;
        tick();
        start_frame();
        bang_frame(~b, 1'b0, 1'b0);
        wait_valid();
        check_word(~b, 1'b0, 1'b0);
    endtask

    task automatic busy_case(input uart_byte_t b);
        loop_mode   = 1'b1;
        start_frame();
        tx_req.data = b;
        tx_req.send = 1'b1;
        tick();
        tx_req.send = 1'b0;
        while (case_cyc < 5 * N)
            tick();
        tx_req.data = ~b; // lands in the data bits and has to be dropped
        tx_req.send = 1'b1;
        tick();
        tx_req.send = 1'b0;
        wait_valid();
        check_word(b, 1'b0, 1'b0);
        start_frame();
        while (case_cyc < 12 * N)
            tick();
        check_val("second pulse", 0, pulses);
        check_val("tx_busy after frame", 0, tx_busy);
    endtask

    task automatic run_case(input string kind, input uart_byte_t b, input int reps);
        for (int r = 0; r < reps; r++) begin
            if (kind == "loop") begin
                loop_byte(b);
            end else if (kind == "badpar") begin
                bang_checked(b, 1'b1, 1'b0);
            end else if (kind == "badstop") begin
                bang_checked(b, 1'b0, 1'b1);
            end else if (kind == "notready") begin
                not_ready_case(b);
            end else if (kind == "busy") begin
                busy_case(b);
            end else begin
                rng = lcg_step(rng);
                loop_byte(rng[23:16]);
            end
            repeat (N) tick(); // idle line between frames
        end
    endtask

    initial begin
        clk         = 1'b0;
        nRst        = 1'b0;
        tx_req      = '0;
        rec_ready   = 1'b1;
        bang_line   = 1'b1;
        loop_mode   = 1'b1;
        cycle_cnt   = 0;
        cycle_limit = 0;
        case_cyc    = 0;
        pulses      = 0;
        got_word    = '0;
        rng         = 32'd87497;
        cur_name    = "reset";

        read_cases();
        cycle_limit = total_frames * 13 * N + 200;

        repeat (8) @(posedge clk);
        #1;
        nRst = 1'b1;
        repeat (2) tick();
        check_val("tx_serial idle", 1, tx_serial);
        check_val("tx_busy idle", 0, tx_busy);
        check_val("rx_valid after reset", 0, rx_valid);
        check_val("rx_word after reset", 0, rx_word);

        for (int c = 0; c < case_names.size(); c++) begin
            cur_name = case_names[c];
            run_case(case_kinds[c], case_bytes[c], case_reps[c]);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

//--- uart_link.f
verilog/uart_cfg_pkg.sv
verilog/uart_msg_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_link_top.sv
dv/uart_link_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the UART link testbench with Verilator and runs it once
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --timescale 1ns/1ps \
    -Wno-fatal \
    --top-module uart_link_tb \
    -f uart_link.f

sim_out=$(./obj_dir/Vuart_link_tb 2>&1) || true
echo "$sim_out"

if grep -qx "Everything OK" <<< "$sim_out"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- dv/uart_cases.txt
# name kind byte(hex) repeat
# kinds are loop badpar badstop notready busy rand and rand draws its bytes from the lcg
loop_zero loop 00 1
loop_ones loop ff 1
loop_a5 loop a5 1
loop_5a loop 5a 1
loop_01 loop 01 2
loop_80 loop 80 1
loop_3c loop 3c 1
par_00 badpar 00 1
par_ff badpar ff 1
par_96 badpar 96 1
par_01 badpar 01 1
stop_55 badstop 55 1
stop_aa badstop aa 1
stop_00 badstop 00 1
stop_e7 badstop e7 1
nrdy_c3 notready c3 1
nrdy_18 notready 18 1
nrdy_7f notready 7f 1
busy_42 busy 42 1
busy_bd busy bd 1
busy_f0 busy f0 1
rand_a rand 00 8
rand_b rand 00 8
loop_end loop 69 1
